// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= rv_core_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulator exit status carries pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/rv_core_checker.sv ====
`timescale 1ns/1ps

module rv_core_checker (
	input  logic               clk,
	input  logic               rst,
	input  logic               inst_valid_i,
	input  rv_pkg::inst_t      inst_i,
	input  logic               wb_en_i,
	input  rv_pkg::reg_addr_t  wb_addr_i,
	input  rv_pkg::word_t      wb_data_i,
	input  logic               illegal_i
);

	logic [2:0] pipe_valid;
	rv_pkg::inst_t pipe_inst [3];
	rv_pkg::word_t shadow [rv_pkg::REG_COUNT];

	logic exp_en;
	logic exp_illegal;
	rv_pkg::reg_addr_t exp_rd;
	rv_pkg::word_t exp_data;

	bit fail_seen = 1'b0;

	// write on the port this cycle is not in the shadow yet
	function automatic rv_pkg::word_t read_reg(rv_pkg::reg_addr_t addr);
		rv_pkg::word_t val;
		if (addr == '0)
			val = '0;
		else if (wb_en_i && wb_addr_i == addr)
			val = wb_data_i;
		else
			val = shadow[addr];
		return val;
	endfunction

	function automatic logic is_legal(rv_pkg::inst_t inst);
		logic [2:0] f3;
		logic [6:0] f7;
		logic ok;
		f3 = inst[14:12];
		f7 = inst[31:25];
		ok = 1'b0;
		if (inst[6:0] == rv_pkg::OPC_LUI)
			ok = 1'b1;
		else if (inst[6:0] == rv_pkg::OPC_OPI)
		begin
			if (f3 == rv_pkg::F3_SLL)
				ok = (f7 == rv_pkg::F7_BASE);
			else if (f3 == rv_pkg::F3_SRL_SRA)
				ok = (f7 == rv_pkg::F7_BASE) || (f7 == rv_pkg::F7_ALT);
			else
				ok = (f3 != 3'b010) && (f3 != 3'b011);
		end
		else if (inst[6:0] == rv_pkg::OPC_OP)
		begin
			if (f7 == rv_pkg::F7_ALT)
				ok = (f3 == rv_pkg::F3_ADD_SUB) || (f3 == rv_pkg::F3_SRL_SRA);
			else if (f7 == rv_pkg::F7_BASE)
				ok = (f3 != 3'b010) && (f3 != 3'b011);
		end
		return ok;
	endfunction

	// sign bit fills the vacated upper bits
	function automatic rv_pkg::word_t shift_right_arith(rv_pkg::word_t a, logic [4:0] sh);
		rv_pkg::word_t fill;
		fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
		return (a >> sh) | fill;
	endfunction

	function automatic rv_pkg::word_t predict(rv_pkg::inst_t inst);
		rv_pkg::word_t a;
		rv_pkg::word_t b;
		rv_pkg::word_t res;
		logic [2:0] f3;
		f3 = inst[14:12];
		a = read_reg(inst[19:15]);
		if (inst[6:0] == rv_pkg::OPC_OP)
			b = read_reg(inst[24:20]);
		else
			b = {{20{inst[31]}}, inst[31:20]};
		case (f3)
			rv_pkg::F3_ADD_SUB:
				res = (inst[6:0] == rv_pkg::OPC_OP && inst[30]) ? a - b : a + b;
			rv_pkg::F3_SLL:
				res = a << b[4:0];
			rv_pkg::F3_XOR:
				res = a ^ b;
			rv_pkg::F3_SRL_SRA:
				res = inst[30] ? shift_right_arith(a, b[4:0]) : a >> b[4:0];
			rv_pkg::F3_OR:
				res = a | b;
			rv_pkg::F3_AND:
				res = a & b;
			default:
				res = '0;
		endcase
		if (inst[6:0] == rv_pkg::OPC_LUI)
			res = {inst[31:12], 12'h000};
		return res;
	endfunction

	// pipe_inst[2] holds the instruction whose result shows on the next edge
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pipe_valid <= '0;
			exp_en <= 1'b0;
			exp_illegal <= 1'b0;
			exp_rd <= '0;
			exp_data <= '0;
			for (int i = 0; i < rv_pkg::REG_COUNT; i++)
				shadow[i] <= '0;
		end
		else
		begin
			pipe_valid <= {pipe_valid[1:0], inst_valid_i};
			pipe_inst[0] <= inst_i;
			pipe_inst[1] <= pipe_inst[0];
			pipe_inst[2] <= pipe_inst[1];
			exp_en <= pipe_valid[2] && is_legal(pipe_inst[2]) && pipe_inst[2][11:7] != '0;
			exp_illegal <= pipe_valid[2] && !is_legal(pipe_inst[2]);
			exp_rd <= pipe_inst[2][11:7];
			exp_data <= predict(pipe_inst[2]);
			if (wb_en_i)
				shadow[wb_addr_i] <= wb_data_i;
		end
	end

	a_wb_en: assert property (@(posedge clk) disable iff (rst) wb_en_i == exp_en)
	else
	begin
		fail_seen = 1'b1;
		$error("ERROR wb_en_o got %h expected %h", $sampled(wb_en_i), $sampled(exp_en));
	end

	a_wb_addr: assert property (@(posedge clk) disable iff (rst)
		exp_en |-> wb_addr_i == exp_rd)
	else
	begin
		fail_seen = 1'b1;
		$error("ERROR wb_addr_o got %h expected %h", $sampled(wb_addr_i), $sampled(exp_rd));
	end

	a_wb_data: assert property (@(posedge clk) disable iff (rst)
		exp_en |-> wb_data_i == exp_data)
	else
	begin
		fail_seen = 1'b1;
		$error("ERROR wb_data_o got %h expected %h", $sampled(wb_data_i), $sampled(exp_data));
	end

	a_illegal: assert property (@(posedge clk) disable iff (rst) illegal_i == exp_illegal)
	else
	begin
		fail_seen = 1'b1;
		$error("ERROR illegal_o got %h expected %h", $sampled(illegal_i), $sampled(exp_illegal));
	end

	a_illegal_no_write: assert property (@(posedge clk) disable iff (rst)
		illegal_i |-> !wb_en_i)
	else
	begin
		fail_seen = 1'b1;
		$error("illegal instruction wrote register %h", $sampled(wb_addr_i));
	end

endmodule

// ==== dv/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

	logic clk;
	logic rst;
	logic inst_valid;
	rv_pkg::inst_t inst;
	logic wb_en;
	rv_pkg::reg_addr_t wb_addr;
	rv_pkg::word_t wb_data;
	logic illegal;

	integer seed;

	tb_clk_gen clk_gen_i (
		.clk_o (clk),
		.rst_o (rst)
	);

	rv_core dut_i (
		.clk          (clk),
		.rst          (rst),
		.inst_valid_i (inst_valid),
		.inst_i       (inst),
		.wb_en_o      (wb_en),
		.wb_addr_o    (wb_addr),
		.wb_data_o    (wb_data),
		.illegal_o    (illegal)
	);

	bind rv_core rv_core_checker checker_i (
		.clk          (clk),
		.rst          (rst),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.wb_en_i      (wb_en_o),
		.wb_addr_i    (wb_addr_o),
		.wb_data_i    (wb_data_o),
		.illegal_i    (illegal_o)
	);

	task automatic stop_with_failure(input string why);
		$display("ERRORS FOUND");
		$fatal(1, "%s", why);
	endtask

	function automatic rv_pkg::word_t rand_word();
		return $random(seed);
	endfunction

	function automatic rv_pkg::reg_addr_t rand_reg();
		rv_pkg::word_t r;
		r = $random(seed);
		return r[4:0];
	endfunction

	function automatic rv_pkg::reg_addr_t nonzero_reg();
		rv_pkg::word_t r;
		r = $random(seed);
		return (r[4:0] == '0) ? 5'd1 : r[4:0];
	endfunction

	// instruction encoders
	function automatic rv_pkg::inst_t reg_op(logic [6:0] f7, logic [2:0] f3,
		rv_pkg::reg_addr_t rd, rv_pkg::reg_addr_t rs1, rv_pkg::reg_addr_t rs2);
		return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
	endfunction

	function automatic rv_pkg::inst_t imm_op(logic [2:0] f3, rv_pkg::reg_addr_t rd,
		rv_pkg::reg_addr_t rs1, logic [11:0] imm);
		return {imm, rs1, f3, rd, rv_pkg::OPC_OPI};
	endfunction

	function automatic rv_pkg::inst_t shift_op(logic [6:0] f7, logic [2:0] f3,
		rv_pkg::reg_addr_t rd, rv_pkg::reg_addr_t rs1, logic [4:0] shamt);
		return {f7, shamt, rs1, f3, rd, rv_pkg::OPC_OPI};
	endfunction

	function automatic rv_pkg::inst_t lui_word(rv_pkg::reg_addr_t rd, logic [19:0] imm);
		return {imm, rd, rv_pkg::OPC_LUI};
	endfunction

	task automatic issue(input rv_pkg::inst_t word);
		@(negedge clk);
		inst_valid = 1'b1;
		inst = word;
	endtask

	// random garbage on inst while valid is low
	task automatic step_idle();
		@(negedge clk);
		inst_valid = 1'b0;
		inst = rand_word();
	endtask

	task automatic idle(input int cycles);
		for (int i = 0; i < cycles; i++)
			step_idle();
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		@(negedge clk);
		while (rst)
		begin
			if (n == 20)
				stop_with_failure("reset was never released");
			@(negedge clk);
			n++;
		end
	endtask

	task automatic wait_write(input rv_pkg::reg_addr_t rd, input rv_pkg::word_t data);
		int n;
		n = 0;
		while (!(wb_en && wb_addr == rd && wb_data == data))
		begin
			if (n == 8)
				stop_with_failure("timeout waiting for the final register write");
			step_idle();
			n++;
		end
	endtask

	task automatic expect_illegal(input rv_pkg::inst_t word);
		int n;
		issue(word);
		n = 0;
		while (!illegal)
		begin
			if (n == 8)
				stop_with_failure("timeout waiting for illegal_o after a bad instruction");
			step_idle();
			n++;
		end
	endtask

	task automatic init_regs();
		rv_pkg::word_t r;
		for (int i = 1; i < rv_pkg::REG_COUNT; i++)
		begin
			r = rand_word();
			issue(lui_word(rv_pkg::reg_addr_t'(i), r[31:12]));
			issue(imm_op(rv_pkg::F3_ADD_SUB, rv_pkg::reg_addr_t'(i), rv_pkg::reg_addr_t'(i),
				r[11:0]));
		end
	endtask

	task automatic imm_round();
		rv_pkg::word_t r;
		r = rand_word();
		issue(lui_word(nonzero_reg(), r[19:0]));
		issue(imm_op(rv_pkg::F3_ADD_SUB, nonzero_reg(), rand_reg(), r[31:20]));
		r = rand_word();
		issue(imm_op(rv_pkg::F3_XOR, nonzero_reg(), rand_reg(), r[11:0]));
		issue(imm_op(rv_pkg::F3_OR, nonzero_reg(), rand_reg(), r[23:12]));
		r = rand_word();
		issue(imm_op(rv_pkg::F3_AND, nonzero_reg(), rand_reg(), r[11:0]));
		issue(shift_op(rv_pkg::F7_BASE, rv_pkg::F3_SLL, nonzero_reg(), rand_reg(), r[16:12]));
		issue(shift_op(rv_pkg::F7_BASE, rv_pkg::F3_SRL_SRA, nonzero_reg(), rand_reg(), r[21:17]));
		issue(shift_op(rv_pkg::F7_ALT, rv_pkg::F3_SRL_SRA, nonzero_reg(), rand_reg(), r[26:22]));
	endtask

	task automatic reg_round();
		issue(reg_op(rv_pkg::F7_BASE, rv_pkg::F3_ADD_SUB, nonzero_reg(), rand_reg(), rand_reg()));
		issue(reg_op(rv_pkg::F7_ALT, rv_pkg::F3_ADD_SUB, nonzero_reg(), rand_reg(), rand_reg()));
		issue(reg_op(rv_pkg::F7_BASE, rv_pkg::F3_SLL, nonzero_reg(), rand_reg(), rand_reg()));
		issue(reg_op(rv_pkg::F7_BASE, rv_pkg::F3_XOR, nonzero_reg(), rand_reg(), rand_reg()));
		issue(reg_op(rv_pkg::F7_BASE, rv_pkg::F3_SRL_SRA, nonzero_reg(), rand_reg(), rand_reg()));
		issue(reg_op(rv_pkg::F7_ALT, rv_pkg::F3_SRL_SRA, nonzero_reg(), rand_reg(), rand_reg()));
		issue(reg_op(rv_pkg::F7_BASE, rv_pkg::F3_OR, nonzero_reg(), rand_reg(), rand_reg()));
		issue(reg_op(rv_pkg::F7_BASE, rv_pkg::F3_AND, nonzero_reg(), rand_reg(), rand_reg()));
	endtask

	// each instruction rewrites the register written d slots earlier
	task automatic forward_chain(input int d);
		rv_pkg::reg_addr_t dst;
		rv_pkg::word_t r;
		for (int j = 0; j < 12; j++)
		begin
			dst = rv_pkg::reg_addr_t'(10 + (j % d));
			r = rand_word();
			case (j % 4)
				0:
					issue(reg_op(rv_pkg::F7_BASE, rv_pkg::F3_ADD_SUB, dst, dst, rand_reg()));
				1:
					issue(reg_op(rv_pkg::F7_ALT, rv_pkg::F3_ADD_SUB, dst, rand_reg(), dst));
				2:
					issue(imm_op(rv_pkg::F3_XOR, dst, dst, r[11:0]));
				default:
					issue(reg_op(rv_pkg::F7_BASE, rv_pkg::F3_ADD_SUB, dst, dst, dst));
			endcase
		end
		idle(2);
	endtask

	always @(negedge clk)
	begin
		if (dut_i.checker_i.fail_seen)
			stop_with_failure("a checker assertion failed");
	end

	initial
	begin
		seed = 32'h682f;
		inst_valid = 1'b0;
		inst = '0;
		wait_reset_release();
		idle(3);

		init_regs();
		for (int i = 0; i < 6; i++)
			imm_round();
		for (int i = 0; i < 8; i++)
			reg_round();

		// negative operand for the arithmetic shifts
		issue(lui_word(5'd5, 20'h80f0f));
		issue(imm_op(rv_pkg::F3_ADD_SUB, 5'd6, 5'd0, 12'd7));
		issue(reg_op(rv_pkg::F7_ALT, rv_pkg::F3_SRL_SRA, 5'd7, 5'd5, 5'd6));
		issue(shift_op(rv_pkg::F7_ALT, rv_pkg::F3_SRL_SRA, 5'd8, 5'd5, 5'd31));
		idle(1);

		for (int d = 1; d <= 3; d++)
			forward_chain(d);

		// x0 as destination and as source
		issue(imm_op(rv_pkg::F3_ADD_SUB, 5'd0, 5'd1, 12'h123));
		issue(lui_word(5'd0, 20'hfffff));
		issue(reg_op(rv_pkg::F7_BASE, rv_pkg::F3_OR, 5'd4, 5'd0, 5'd0));
		issue(imm_op(rv_pkg::F3_ADD_SUB, 5'd5, 5'd0, 12'h7ff));
		issue(reg_op(rv_pkg::F7_ALT, rv_pkg::F3_ADD_SUB, 5'd6, 5'd0, 5'd5));
		idle(4);

		expect_illegal({12'h004, 5'd2, 3'b010, 5'd3, 7'b0000011});
		expect_illegal(reg_op(7'b0000001, rv_pkg::F3_ADD_SUB, 5'd3, 5'd1, 5'd2));
		expect_illegal(reg_op(rv_pkg::F7_ALT, rv_pkg::F3_XOR, 5'd3, 5'd1, 5'd2));
		expect_illegal(reg_op(rv_pkg::F7_BASE, 3'b010, 5'd3, 5'd1, 5'd2));
		expect_illegal(imm_op(3'b011, 5'd3, 5'd1, 12'h00f));
		expect_illegal(shift_op(rv_pkg::F7_ALT, rv_pkg::F3_SLL, 5'd3, 5'd1, 5'd4));
		expect_illegal(shift_op(7'b0000001, rv_pkg::F3_SRL_SRA, 5'd3, 5'd1, 5'd4));
		expect_illegal(32'h0000_0000);
		expect_illegal(32'hffff_ffff);

		// marker write tells when the pipeline has drained
		issue(lui_word(5'd31, 20'h5a5a5));
		wait_write(5'd31, 32'h5a5a_5000);
		idle(2);

		if (dut_i.checker_i.fail_seen)
			stop_with_failure("a checker assertion failed");
		else
		begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o,
	output logic rst_o
);

	// 20 ns period
	initial
	begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	// reset held over four rising edges, released on a falling edge
	initial
	begin
		rst_o = 1'b1;
		repeat (4) @(posedge clk_o);
		@(negedge clk_o);
		rst_o = 1'b0;
	end

endmodule

// ==== files.f ====
src/rv_pkg.sv
src/id_decode.sv
src/reg_file.sv
src/ex_stage.sv
src/mem_wb_stage.sv
src/rv_core.sv
dv/tb_clk_gen.sv
dv/rv_core_checker.sv
dv/rv_core_tb.sv

// ==== src/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage (
	input  logic               clk,
	input  logic               rst,
	input  rv_pkg::alu_op_e    op_i,
	input  rv_pkg::word_t      opa_i,
	input  rv_pkg::word_t      opb_i,
	input  logic               we_i,
	input  rv_pkg::reg_addr_t  waddr_i,
	input  logic               valid_i,
	input  logic               illegal_i,
	output rv_pkg::word_t      result_o,
	output logic               we_o,
	output rv_pkg::reg_addr_t  waddr_o,
	output logic               valid_o,
	output logic               illegal_o
);

	rv_pkg::alu_op_e op_q;
	rv_pkg::word_t opa_q;
	rv_pkg::word_t opb_q;
	rv_pkg::reg_addr_t waddr_q;
	logic we_q;
	logic valid_q;
	logic illegal_q;

	logic [4:0] shamt;
	rv_pkg::word_t result;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			we_q <= 1'b0;
			valid_q <= 1'b0;
			illegal_q <= 1'b0;
		end
		else
		begin
			we_q <= we_i;
			valid_q <= valid_i;
			illegal_q <= illegal_i;
		end
		op_q <= op_i;
		opa_q <= opa_i;
		opb_q <= opb_i;
		waddr_q <= waddr_i;
	end

	assign shamt = opb_q[4:0];

	always_comb
	begin
		case (op_q)
			rv_pkg::ADD:
				result = opa_q + opb_q;
			rv_pkg::SUB:
				result = opa_q - opb_q;
			rv_pkg::AND:
				result = opa_q & opb_q;
			rv_pkg::OR:
				result = opa_q | opb_q;
			rv_pkg::XOR:
				result = opa_q ^ opb_q;
			rv_pkg::SLL:
				result = opa_q << shamt;
			rv_pkg::SRL:
				result = opa_q >> shamt;
			rv_pkg::SRA:
				result = rv_pkg::word_t'($signed(opa_q) >>> shamt);
			rv_pkg::PASS:
				result = opb_q;
			default:
				result = '0;
		endcase
	end

	// also the execute bypass source
	assign result_o = result;
	assign we_o = we_q;
	assign waddr_o = waddr_q;
	assign valid_o = valid_q;
	assign illegal_o = illegal_q;

endmodule

// ==== src/id_decode.sv ====
`timescale 1ns/1ps

module id_decode (
	input  logic               clk,
	input  logic               rst,
	input  logic               inst_valid_i,
	input  rv_pkg::inst_t      inst_i,

	// register file read ports
	output logic               rf_rd1_en_o,
	output logic               rf_rd2_en_o,
	output rv_pkg::reg_addr_t  rf_rd1_addr_o,
	output rv_pkg::reg_addr_t  rf_rd2_addr_o,
	input  rv_pkg::word_t      rf_rd1_data_i,
	input  rv_pkg::word_t      rf_rd2_data_i,

	// bypass from execute
	input  logic               ex_we_i,
	input  rv_pkg::reg_addr_t  ex_waddr_i,
	input  rv_pkg::word_t      ex_wdata_i,

	// bypass from memory
	input  logic               mem_we_i,
	input  rv_pkg::reg_addr_t  mem_waddr_i,
	input  rv_pkg::word_t      mem_wdata_i,

	output rv_pkg::alu_op_e    op_o,
	output rv_pkg::word_t      opa_o,
	output rv_pkg::word_t      opb_o,
	output logic               we_o,
	output rv_pkg::reg_addr_t  waddr_o,
	output logic               valid_o,
	output logic               illegal_o
);

	rv_pkg::inst_t inst_q;
	logic valid_q;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	rv_pkg::reg_addr_t rs1;
	rv_pkg::reg_addr_t rs2;
	rv_pkg::reg_addr_t rd;
	rv_pkg::word_t imm_i;
	rv_pkg::word_t imm_u;
	rv_pkg::word_t imm_sh;

	rv_pkg::alu_op_e op;
	rv_pkg::word_t imm;
	logic legal;
	logic use_rs1;
	logic use_rs2;

	always_ff @(posedge clk)
	begin
		if (rst)
			valid_q <= 1'b0;
		else
			valid_q <= inst_valid_i;
		inst_q <= inst_i;
	end

	assign opcode = inst_q[6:0];
	assign rd = inst_q[11:7];
	assign funct3 = inst_q[14:12];
	assign rs1 = inst_q[19:15];
	assign rs2 = inst_q[24:20];
	assign funct7 = inst_q[31:25];

	assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
	assign imm_u = {inst_q[31:12], 12'b0};
	assign imm_sh = {27'b0, inst_q[24:20]};

	always_comb
	begin
		op = rv_pkg::NOP;
		imm = imm_i;
		legal = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (opcode)
			rv_pkg::OPC_LUI:
			begin
				op = rv_pkg::PASS;
				imm = imm_u;
				legal = 1'b1;
			end
			rv_pkg::OPC_OPI:
			begin
				use_rs1 = 1'b1;
				case (funct3)
					rv_pkg::F3_ADD_SUB:
					begin
						op = rv_pkg::ADD;
						legal = 1'b1;
					end
					rv_pkg::F3_XOR:
					begin
						op = rv_pkg::XOR;
						legal = 1'b1;
					end
					rv_pkg::F3_OR:
					begin
						op = rv_pkg::OR;
						legal = 1'b1;
					end
					rv_pkg::F3_AND:
					begin
						op = rv_pkg::AND;
						legal = 1'b1;
					end
					rv_pkg::F3_SLL:
					begin
						imm = imm_sh;
						if (funct7 == rv_pkg::F7_BASE)
						begin
							op = rv_pkg::SLL;
							legal = 1'b1;
						end
					end
					rv_pkg::F3_SRL_SRA:
					begin
						imm = imm_sh;
						if (funct7 == rv_pkg::F7_BASE)
						begin
							op = rv_pkg::SRL;
							legal = 1'b1;
						end
						else if (funct7 == rv_pkg::F7_ALT)
						begin
							op = rv_pkg::SRA;
							legal = 1'b1;
						end
					end
					default:
					begin
						legal = 1'b0;
					end
				endcase
			end
			rv_pkg::OPC_OP:
			begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				legal = (funct7 == rv_pkg::F7_BASE);
				case (funct3)
					rv_pkg::F3_ADD_SUB:
					begin
						op = (funct7 == rv_pkg::F7_ALT) ? rv_pkg::SUB : rv_pkg::ADD;
						legal = legal || (funct7 == rv_pkg::F7_ALT);
					end
					rv_pkg::F3_SRL_SRA:
					begin
						op = (funct7 == rv_pkg::F7_ALT) ? rv_pkg::SRA : rv_pkg::SRL;
						legal = legal || (funct7 == rv_pkg::F7_ALT);
					end
					rv_pkg::F3_SLL:
						op = rv_pkg::SLL;
					rv_pkg::F3_XOR:
						op = rv_pkg::XOR;
					rv_pkg::F3_OR:
						op = rv_pkg::OR;
					rv_pkg::F3_AND:
						op = rv_pkg::AND;
					default:
						legal = 1'b0;
				endcase
			end
			default:
			begin
				legal = 1'b0;
			end
		endcase
	end

	assign rf_rd1_en_o = valid_q && legal && use_rs1;
	assign rf_rd2_en_o = valid_q && legal && use_rs2;
	assign rf_rd1_addr_o = rs1;
	assign rf_rd2_addr_o = rs2;

	// youngest producer wins, reg file covers write-back
	assign opa_o = !rf_rd1_en_o ? '0 :
		(ex_we_i && ex_waddr_i == rs1) ? ex_wdata_i :
		(mem_we_i && mem_waddr_i == rs1) ? mem_wdata_i : rf_rd1_data_i;

	assign opb_o = !rf_rd2_en_o ? imm :
		(ex_we_i && ex_waddr_i == rs2) ? ex_wdata_i :
		(mem_we_i && mem_waddr_i == rs2) ? mem_wdata_i : rf_rd2_data_i;

	assign op_o = op;
	assign we_o = valid_q && legal && (rd != '0);
	assign waddr_o = rd;
	assign valid_o = valid_q;
	assign illegal_o = !legal;

endmodule

// ==== src/mem_wb_stage.sv ====
`timescale 1ns/1ps

module mem_wb_stage (
	input  logic               clk,
	input  logic               rst,
	input  rv_pkg::word_t      result_i,
	input  logic               we_i,
	input  rv_pkg::reg_addr_t  waddr_i,
	input  logic               valid_i,
	input  logic               illegal_i,
	output rv_pkg::word_t      mem_wdata_o,
	output logic               mem_we_o,
	output rv_pkg::reg_addr_t  mem_waddr_o,
	output rv_pkg::word_t      wb_data_o,
	output logic               wb_we_o,
	output rv_pkg::reg_addr_t  wb_addr_o,
	output logic               wb_illegal_o
);

	rv_pkg::word_t mem_data_q;
	rv_pkg::reg_addr_t mem_addr_q;
	logic mem_we_q;
	logic mem_valid_q;
	logic mem_illegal_q;

	rv_pkg::word_t wb_data_q;
	rv_pkg::reg_addr_t wb_addr_q;
	logic wb_we_q;
	logic wb_illegal_q;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			mem_we_q <= 1'b0;
			mem_valid_q <= 1'b0;
			mem_illegal_q <= 1'b0;
			wb_we_q <= 1'b0;
			wb_illegal_q <= 1'b0;
		end
		else
		begin
			mem_we_q <= we_i;
			mem_valid_q <= valid_i;
			mem_illegal_q <= illegal_i;
			wb_we_q <= mem_we_q;
			// only a real instruction flags illegal
			wb_illegal_q <= mem_valid_q && mem_illegal_q;
		end
		mem_data_q <= result_i;
		mem_addr_q <= waddr_i;
		wb_data_q <= mem_data_q;
		wb_addr_q <= mem_addr_q;
	end

	assign mem_wdata_o = mem_data_q;
	assign mem_we_o = mem_we_q;
	assign mem_waddr_o = mem_addr_q;

	assign wb_data_o = wb_data_q;
	assign wb_we_o = wb_we_q;
	assign wb_addr_o = wb_addr_q;
	assign wb_illegal_o = wb_illegal_q;

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
	input  logic               clk,
	input  logic               rst,
	input  logic               rd1_en_i,
	input  logic               rd2_en_i,
	input  rv_pkg::reg_addr_t  rd1_addr_i,
	input  rv_pkg::reg_addr_t  rd2_addr_i,
	output rv_pkg::word_t      rd1_data_o,
	output rv_pkg::word_t      rd2_data_o,
	input  logic               we_i,
	input  rv_pkg::reg_addr_t  waddr_i,
	input  rv_pkg::word_t      wdata_i
);

	rv_pkg::word_t regs [rv_pkg::REG_COUNT];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < rv_pkg::REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (we_i && waddr_i != '0)
		begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// x0 reads as zero, same-cycle write is passed through
	assign rd1_data_o = (!rd1_en_i || rd1_addr_i == '0) ? '0 :
		(we_i && waddr_i == rd1_addr_i) ? wdata_i : regs[rd1_addr_i];

	assign rd2_data_o = (!rd2_en_i || rd2_addr_i == '0) ? '0 :
		(we_i && waddr_i == rd2_addr_i) ? wdata_i : regs[rd2_addr_i];

endmodule

// ==== src/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
	input  logic               clk,
	input  logic               rst,
	input  logic               inst_valid_i,
	input  rv_pkg::inst_t      inst_i,
	output logic               wb_en_o,
	output rv_pkg::reg_addr_t  wb_addr_o,
	output rv_pkg::word_t      wb_data_o,
	output logic               illegal_o
);

	// decode to register file
	logic rd1_en;
	logic rd2_en;
	rv_pkg::reg_addr_t rd1_addr;
	rv_pkg::reg_addr_t rd2_addr;
	rv_pkg::word_t rd1_data;
	rv_pkg::word_t rd2_data;

	// decode to execute
	rv_pkg::alu_op_e id_op;
	rv_pkg::word_t id_opa;
	rv_pkg::word_t id_opb;
	logic id_we;
	rv_pkg::reg_addr_t id_waddr;
	logic id_valid;
	logic id_illegal;

	// execute outputs, also the first bypass
	rv_pkg::word_t ex_result;
	logic ex_we;
	rv_pkg::reg_addr_t ex_waddr;
	logic ex_valid;
	logic ex_illegal;

	// memory stage bypass
	rv_pkg::word_t mem_wdata;
	logic mem_we;
	rv_pkg::reg_addr_t mem_waddr;

	id_decode id_decode_i (
		.clk           (clk),
		.rst           (rst),
		.inst_valid_i  (inst_valid_i),
		.inst_i        (inst_i),
		.rf_rd1_en_o   (rd1_en),
		.rf_rd2_en_o   (rd2_en),
		.rf_rd1_addr_o (rd1_addr),
		.rf_rd2_addr_o (rd2_addr),
		.rf_rd1_data_i (rd1_data),
		.rf_rd2_data_i (rd2_data),
		.ex_we_i       (ex_we),
		.ex_waddr_i    (ex_waddr),
		.ex_wdata_i    (ex_result),
		.mem_we_i      (mem_we),
		.mem_waddr_i   (mem_waddr),
		.mem_wdata_i   (mem_wdata),
		.op_o          (id_op),
		.opa_o         (id_opa),
		.opb_o         (id_opb),
		.we_o          (id_we),
		.waddr_o       (id_waddr),
		.valid_o       (id_valid),
		.illegal_o     (id_illegal)
	);

	reg_file reg_file_i (
		.clk        (clk),
		.rst        (rst),
		.rd1_en_i   (rd1_en),
		.rd2_en_i   (rd2_en),
		.rd1_addr_i (rd1_addr),
		.rd2_addr_i (rd2_addr),
		.rd1_data_o (rd1_data),
		.rd2_data_o (rd2_data),
		.we_i       (wb_en_o),
		.waddr_i    (wb_addr_o),
		.wdata_i    (wb_data_o)
	);

	ex_stage ex_stage_i (
		.clk       (clk),
		.rst       (rst),
		.op_i      (id_op),
		.opa_i     (id_opa),
		.opb_i     (id_opb),
		.we_i      (id_we),
		.waddr_i   (id_waddr),
		.valid_i   (id_valid),
		.illegal_i (id_illegal),
		.result_o  (ex_result),
		.we_o      (ex_we),
		.waddr_o   (ex_waddr),
		.valid_o   (ex_valid),
		.illegal_o (ex_illegal)
	);

	mem_wb_stage mem_wb_stage_i (
		.clk          (clk),
		.rst          (rst),
		.result_i     (ex_result),
		.we_i         (ex_we),
		.waddr_i      (ex_waddr),
		.valid_i      (ex_valid),
		.illegal_i    (ex_illegal),
		.mem_wdata_o  (mem_wdata),
		.mem_we_o     (mem_we),
		.mem_waddr_o  (mem_waddr),
		.wb_data_o    (wb_data_o),
		.wb_we_o      (wb_en_o),
		.wb_addr_o    (wb_addr_o),
		.wb_illegal_o (illegal_o)
	);

endmodule

// ==== src/rv_pkg.sv ====
package rv_pkg;

	localparam int REG_COUNT = 32;

	typedef logic [31:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0] reg_addr_t;

	// major opcodes
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_OPI = 7'b0010011;
	localparam logic [6:0] OPC_OP = 7'b0110011;

	// funct3, shared by immediate and register forms
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	// alt form selects SUB and SRA
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT = 7'b0100000;

	// PASS forwards operand two, used by LUI
	typedef enum logic [3:0] {
		NOP,
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SLL,
		SRL,
		SRA,
		PASS
	} alu_op_e;

endpackage
